/* hdl/lsu_config.svh */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Data and address width
`define LSU_XLEN 32

// Destination register tag
`define LSU_TAG_WIDTH 5

// Load station slots, also the width of the one-hot slot index
`define LSU_LOAD_RS_DEPTH 3

// Committed stores waiting for the memory port
`define LSU_STORE_Q_DEPTH 3

`endif

/* hdl/lsu_types_pkg.sv */
`default_nettype none
`include "lsu_config.svh"

package lsu_types_pkg;

  localparam int STORE_CNT_WIDTH = $clog2(`LSU_STORE_Q_DEPTH + 1);

  // RV32I load/store funct3
  typedef enum logic [2:0] {
    mem_b  = 3'b000,
    mem_h  = 3'b001,
    mem_w  = 3'b010,
    mem_bu = 3'b100,
    mem_hu = 3'b101
  } mem_funct3_t;

  typedef struct packed {
    logic [`LSU_TAG_WIDTH-1:0] tag;
    logic [`LSU_XLEN-1:0]      addr;
    mem_funct3_t               funct3;
  } load_entry_t;

  typedef struct packed {
    logic                       valid;
    logic [STORE_CNT_WIDTH-1:0] stores_ahead;  // Older stores still queued
    load_entry_t                entry;
  } load_slot_t;

  typedef struct packed {
    logic [`LSU_XLEN-1:0] addr;
    logic [`LSU_XLEN-1:0] data;  // Unshifted, low bits used for SB/SH
    mem_funct3_t          funct3;
  } store_entry_t;

  typedef struct packed {
    logic [`LSU_TAG_WIDTH-1:0] tag;
    logic [`LSU_XLEN-1:0]      data;
  } load_result_t;

endpackage

`default_nettype wire

/* hdl/mem_bus_pkg.sv */
`default_nettype none
`include "lsu_config.svh"

package mem_bus_pkg;

  typedef struct packed {
    logic                 valid;
    logic                 read;
    logic                 write;
    logic [`LSU_XLEN-3:0] word_addr;  // Byte address bits 31..2
    logic [3:0]           mask;
    logic [`LSU_XLEN-1:0] wdata;      // Already shifted into its lanes
  } dmem_req_t;

  typedef struct packed {
    logic                 resp;
    logic [`LSU_XLEN-1:0] rdata;
  } dmem_rsp_t;

endpackage

`default_nettype wire

/* hdl/load_rs.sv */
`default_nettype none
`include "lsu_config.svh"

module load_rs #(
  parameter int LOAD_RS_DEPTH = `LSU_LOAD_RS_DEPTH
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      move_flush,
  input  logic                                      load_dispatch,
  input  lsu_types_pkg::load_entry_t                load_in,
  input  logic [lsu_types_pkg::STORE_CNT_WIDTH-1:0] store_count,
  input  logic                                      store_rs_pop,
  input  logic                                      load_rs_pop,
  input  logic [LOAD_RS_DEPTH-1:0]                  load_rs_idx_executing,
  output logic                                      dmem_r_rqst,
  output logic [LOAD_RS_DEPTH-1:0]                  load_rs_idx_rqst,
  output lsu_types_pkg::load_entry_t                sel_load,
  output logic                                      load_rs_full
);

  localparam int CNT_W = lsu_types_pkg::STORE_CNT_WIDTH;

  lsu_types_pkg::load_slot_t slot_q [LOAD_RS_DEPTH];
  logic [LOAD_RS_DEPTH-1:0]  valid_vec;
  logic [LOAD_RS_DEPTH-1:0]  ready_vec;
  logic [LOAD_RS_DEPTH-1:0]  free_sel;
  logic [CNT_W-1:0]          stamp;

  always_comb begin
    for (int i = 0; i < LOAD_RS_DEPTH; i++) begin
      valid_vec[i] = slot_q[i].valid;
      ready_vec[i] = slot_q[i].valid && (slot_q[i].stores_ahead == '0);
    end
  end

  // Walk down so the lowest index is the last one to win
  always_comb begin
    load_rs_idx_rqst = '0;
    free_sel         = '0;
    sel_load         = '0;
    for (int i = LOAD_RS_DEPTH - 1; i >= 0; i--) begin
      if (ready_vec[i]) begin
        load_rs_idx_rqst    = '0;
        load_rs_idx_rqst[i] = 1'b1;
        sel_load            = slot_q[i].entry;
      end
      if (!valid_vec[i]) begin
        free_sel    = '0;
        free_sel[i] = 1'b1;
      end
    end
  end

  assign dmem_r_rqst  = |ready_vec;
  assign load_rs_full = &valid_vec;

  // A store leaving on this edge is no longer ahead of the new load
  assign stamp = store_count - CNT_W'(store_rs_pop);

  always_ff @(posedge clk) begin
    for (int i = 0; i < LOAD_RS_DEPTH; i++) begin
      if (!rst_n || move_flush) begin
        slot_q[i].valid        <= 1'b0;
        slot_q[i].stores_ahead <= '0;
      end else if (load_dispatch && free_sel[i]) begin
        slot_q[i].valid        <= 1'b1;
        slot_q[i].stores_ahead <= stamp;
        slot_q[i].entry        <= load_in;
      end else begin
        if (load_rs_pop && load_rs_idx_executing[i]) begin
          slot_q[i].valid <= 1'b0;
        end
        if (store_rs_pop && (slot_q[i].stores_ahead != '0)) begin
          slot_q[i].stores_ahead <= slot_q[i].stores_ahead - 1'b1;
        end
      end
    end
  end

  // The index latched by the FSM must still point at a live load
  property p_pop_names_one_slot;
    @(posedge clk) disable iff (!rst_n)
      load_rs_pop |-> $onehot(load_rs_idx_executing) &&
                      |(load_rs_idx_executing & valid_vec);
  endproperty

  a_pop_names_one_slot: assert property (p_pop_names_one_slot);

endmodule

`default_nettype wire

/* hdl/store_queue.sv */
`default_nettype none
`include "lsu_config.svh"

module store_queue #(
  parameter int STORE_Q_DEPTH = `LSU_STORE_Q_DEPTH
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      store_commit,
  input  lsu_types_pkg::store_entry_t               store_in,
  input  logic                                      store_rs_pop,
  output logic                                      dmem_w_rqst,
  output lsu_types_pkg::store_entry_t               head,
  output logic [lsu_types_pkg::STORE_CNT_WIDTH-1:0] store_count,
  output logic                                      store_q_full
);

  localparam int PTR_W = (STORE_Q_DEPTH > 1) ? $clog2(STORE_Q_DEPTH) : 1;
  localparam int CNT_W = lsu_types_pkg::STORE_CNT_WIDTH;

  lsu_types_pkg::store_entry_t mem_q [STORE_Q_DEPTH];
  logic [PTR_W-1:0]            wr_ptr;
  logic [PTR_W-1:0]            rd_ptr;
  logic [CNT_W-1:0]            count;
  logic                        push;
  logic                        pop;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(STORE_Q_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push = store_commit && !store_q_full;
  assign pop  = store_rs_pop && dmem_w_rqst;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr] <= store_in;
    end
  end

  assign dmem_w_rqst  = (count != '0);
  assign head         = mem_q[rd_ptr];
  assign store_count  = count;
  assign store_q_full = (count == CNT_W'(STORE_Q_DEPTH));

  // Commit side must honour the full flag
  a_no_push_when_full: assert property (
    @(posedge clk) disable iff (!rst_n) store_commit |-> !store_q_full
  );

  // Arbiter only pops a store it was granted
  a_no_pop_when_empty: assert property (
    @(posedge clk) disable iff (!rst_n) store_rs_pop |-> dmem_w_rqst
  );

endmodule

`default_nettype wire

/* hdl/load_store_fsm.sv */
`default_nettype none
`include "lsu_config.svh"

module load_store_fsm #(
  parameter int LOAD_RS_DEPTH = `LSU_LOAD_RS_DEPTH
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     move_flush,
  input  logic                     dmem_resp,
  input  logic                     dmem_r_rqst,
  input  logic                     dmem_w_rqst,
  input  logic [LOAD_RS_DEPTH-1:0] load_rs_idx_rqst,
  output logic                     arbiter_load_rs,
  output logic                     arbiter_store_rs,
  output logic [LOAD_RS_DEPTH-1:0] load_rs_idx_executing,
  output logic                     load_rs_pop,
  output logic                     store_rs_pop
);

  typedef enum logic [1:0] {
    st_idle,
    st_r_stall,
    st_w_stall
  } state_t;

  state_t                   state_q;
  state_t                   state_d;
  logic [LOAD_RS_DEPTH-1:0] idx_executing_q;  // Slot granted to the read in flight

  always_ff @(posedge clk) begin
    if (!rst_n || move_flush) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || move_flush) begin
      idx_executing_q <= '0;
    end else if (arbiter_load_rs) begin
      idx_executing_q <= load_rs_idx_rqst;
    end else if (load_rs_pop) begin
      idx_executing_q <= '0;
    end
  end

  always_comb begin
    state_d               = state_q;
    arbiter_load_rs       = 1'b0;
    arbiter_store_rs      = 1'b0;
    load_rs_pop           = 1'b0;
    store_rs_pop          = 1'b0;
    load_rs_idx_executing = '0;

    case (state_q)
      st_idle: begin
        if (dmem_w_rqst) begin  // Writes first
          state_d          = st_w_stall;
          arbiter_store_rs = !move_flush;
        end else if (dmem_r_rqst) begin
          state_d         = st_r_stall;
          arbiter_load_rs = !move_flush;
        end
      end
      st_r_stall: begin
        if (dmem_resp) begin
          state_d               = st_idle;
          load_rs_pop           = 1'b1;
          load_rs_idx_executing = idx_executing_q;
        end
      end
      st_w_stall: begin
        if (dmem_resp) begin
          state_d      = st_idle;
          store_rs_pop = 1'b1;
        end
      end
      default: state_d = st_idle;
    endcase
  end

  // A flush mid-request would orphan the response
  a_no_flush_in_stall: assert property (
    @(posedge clk) disable iff (!rst_n) move_flush |-> (state_q == st_idle)
  );

endmodule

`default_nettype wire

/* hdl/dmem_port.sv */
`default_nettype none
`include "lsu_config.svh"

module dmem_port (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        arbiter_load_rs,
  input  logic                        arbiter_store_rs,
  input  lsu_types_pkg::load_entry_t  sel_load,
  input  lsu_types_pkg::store_entry_t head,
  input  mem_bus_pkg::dmem_rsp_t      dmem_rsp,
  output mem_bus_pkg::dmem_req_t      dmem_req,
  output logic                        dmem_resp,
  output lsu_types_pkg::load_result_t load_result,
  output logic                        load_result_valid
);

  localparam int XLEN = `LSU_XLEN;

  logic                       req_valid;
  logic                       req_read;
  logic                       req_write;
  logic [XLEN-3:0]            req_word_addr;
  logic [3:0]                 req_mask;
  logic [XLEN-1:0]            req_wdata;
  logic [`LSU_TAG_WIDTH-1:0]  ld_tag_q;
  lsu_types_pkg::mem_funct3_t ld_funct3_q;
  logic [1:0]                 ld_offset_q;

  function automatic logic [3:0] byte_mask(input lsu_types_pkg::mem_funct3_t funct3,
                                           input logic [1:0] offset);
    case (funct3)
      lsu_types_pkg::mem_b, lsu_types_pkg::mem_bu: return 4'b0001 << offset;
      lsu_types_pkg::mem_h, lsu_types_pkg::mem_hu: return 4'b0011 << offset;
      default: return 4'b1111;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] write_lanes(input lsu_types_pkg::store_entry_t st);
    logic [XLEN-1:0] raw;
    case (st.funct3)
      lsu_types_pkg::mem_b, lsu_types_pkg::mem_bu: raw = {{(XLEN-8){1'b0}}, st.data[7:0]};
      lsu_types_pkg::mem_h, lsu_types_pkg::mem_hu: raw = {{(XLEN-16){1'b0}}, st.data[15:0]};
      default: raw = st.data;
    endcase
    return raw << {st.addr[1:0], 3'b000};
  endfunction

  function automatic logic [XLEN-1:0] extend_load(input lsu_types_pkg::mem_funct3_t funct3,
                                                  input logic [1:0] offset,
                                                  input logic [XLEN-1:0] rdata);
    logic [XLEN-1:0] shifted;
    shifted = rdata >> {offset, 3'b000};  // Wanted lane down to bit 0
    case (funct3)
      lsu_types_pkg::mem_b:  return {{(XLEN-8){shifted[7]}}, shifted[7:0]};
      lsu_types_pkg::mem_bu: return {{(XLEN-8){1'b0}}, shifted[7:0]};
      lsu_types_pkg::mem_h:  return {{(XLEN-16){shifted[15]}}, shifted[15:0]};
      lsu_types_pkg::mem_hu: return {{(XLEN-16){1'b0}}, shifted[15:0]};
      default: return shifted;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_valid <= 1'b0;
      req_read  <= 1'b0;
      req_write <= 1'b0;
    end else if (arbiter_store_rs || arbiter_load_rs) begin
      req_valid <= 1'b1;
      req_read  <= arbiter_load_rs;
      req_write <= arbiter_store_rs;
    end else if (dmem_rsp.resp) begin  // Held through the resp cycle
      req_valid <= 1'b0;
      req_read  <= 1'b0;
      req_write <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (arbiter_store_rs) begin
      req_word_addr <= head.addr[XLEN-1:2];
      req_mask      <= byte_mask(head.funct3, head.addr[1:0]);
      req_wdata     <= write_lanes(head);
    end else if (arbiter_load_rs) begin
      req_word_addr <= sel_load.addr[XLEN-1:2];
      req_mask      <= byte_mask(sel_load.funct3, sel_load.addr[1:0]);
      req_wdata     <= '0;
      ld_tag_q      <= sel_load.tag;
      ld_funct3_q   <= sel_load.funct3;
      ld_offset_q   <= sel_load.addr[1:0];
    end
  end

  always_comb begin
    dmem_req.valid     = req_valid;
    dmem_req.read      = req_read;
    dmem_req.write     = req_write;
    dmem_req.word_addr = req_word_addr;
    dmem_req.mask      = req_mask;
    dmem_req.wdata     = req_wdata;
  end

  assign dmem_resp = dmem_rsp.resp;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      load_result_valid <= 1'b0;
    end else begin
      load_result_valid <= dmem_rsp.resp && req_read;
    end
  end

  always_ff @(posedge clk) begin
    if (dmem_rsp.resp && req_read) begin
      load_result.tag  <= ld_tag_q;
      load_result.data <= extend_load(ld_funct3_q, ld_offset_q, dmem_rsp.rdata);
    end
  end

  // FSM must wait for the port to drain before granting again
  a_no_strobe_while_busy: assert property (
    @(posedge clk) disable iff (!rst_n) (arbiter_load_rs || arbiter_store_rs) |-> !req_valid
  );

endmodule

`default_nettype wire

/* hdl/lsu_top.sv */
`default_nettype none
`include "lsu_config.svh"

module lsu_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        move_flush,
  input  logic                        load_dispatch,
  input  lsu_types_pkg::load_entry_t  load_in,
  input  logic                        store_commit,
  input  lsu_types_pkg::store_entry_t store_in,
  input  mem_bus_pkg::dmem_rsp_t      dmem_rsp,
  output mem_bus_pkg::dmem_req_t      dmem_req,
  output lsu_types_pkg::load_result_t load_result,
  output logic                        load_result_valid,
  output logic                        load_rs_full,
  output logic                        store_q_full
);

  localparam int LOAD_RS_DEPTH = `LSU_LOAD_RS_DEPTH;

  logic                                      dmem_r_rqst;
  logic                                      dmem_w_rqst;
  logic                                      dmem_resp;
  logic [LOAD_RS_DEPTH-1:0]                  load_rs_idx_rqst;
  logic [LOAD_RS_DEPTH-1:0]                  load_rs_idx_executing;
  logic                                      arbiter_load_rs;
  logic                                      arbiter_store_rs;
  logic                                      load_rs_pop;
  logic                                      store_rs_pop;
  logic [lsu_types_pkg::STORE_CNT_WIDTH-1:0] store_count;
  lsu_types_pkg::load_entry_t                sel_load;
  lsu_types_pkg::store_entry_t               head;

  load_rs #(.LOAD_RS_DEPTH(LOAD_RS_DEPTH)) load_rs_i (
    .clk, .rst_n, .move_flush, .load_dispatch, .load_in, .store_count,
    .store_rs_pop, .load_rs_pop, .load_rs_idx_executing,
    .dmem_r_rqst, .load_rs_idx_rqst, .sel_load, .load_rs_full
  );

  store_queue #(.STORE_Q_DEPTH(`LSU_STORE_Q_DEPTH)) store_queue_i (
    .clk, .rst_n, .store_commit, .store_in, .store_rs_pop,
    .dmem_w_rqst, .head, .store_count, .store_q_full
  );

  load_store_fsm #(.LOAD_RS_DEPTH(LOAD_RS_DEPTH)) load_store_fsm_i (
    .clk, .rst_n, .move_flush, .dmem_resp, .dmem_r_rqst, .dmem_w_rqst,
    .load_rs_idx_rqst, .arbiter_load_rs, .arbiter_store_rs,
    .load_rs_idx_executing, .load_rs_pop, .store_rs_pop
  );

  dmem_port dmem_port_i (
    .clk, .rst_n, .arbiter_load_rs, .arbiter_store_rs, .sel_load, .head,
    .dmem_rsp, .dmem_req, .dmem_resp, .load_result, .load_result_valid
  );

endmodule

`default_nettype wire

/* sim/lsu_tb.sv */
`default_nettype none
`include "lsu_config.svh"

module lsu_tb;

  logic                        clk;
  logic                        rst_n;
  logic                        move_flush;
  logic                        load_dispatch;
  lsu_types_pkg::load_entry_t  load_in;
  logic                        store_commit;
  lsu_types_pkg::store_entry_t store_in;
  mem_bus_pkg::dmem_rsp_t      dmem_rsp;
  mem_bus_pkg::dmem_req_t      dmem_req;
  lsu_types_pkg::load_result_t load_result;
  logic                        load_result_valid;
  logic                        load_rs_full;
  logic                        store_q_full;

  integer                 seed;
  int                     val_errs, other_errs;
  logic [31:0]            memory [64];  // Memory model behind the port
  logic [31:0]            shadow [64];  // Updated in commit order
  bit                     pend [32];
  bit                     flushed [32];
  logic [5:0]             pend_word [32];
  logic [31:0]            exp_data [32];
  mem_bus_pkg::dmem_req_t exp_writes [$];
  mem_bus_pkg::dmem_req_t cur_req;
  int                     mem_state;  // 0 idle, 1 waiting, 2 resp driven
  int                     mem_cnt;
  int                     sq_cnt;  // Stores visible to arbitration
  int                     sq_cnt_q;  // Same count one cycle earlier
  int                     n_commits, n_writes, n_flushed;
  int                     load_pct, store_pct, flush_pct;
  bit                     slow_mem, full_seen;

  lsu_top lsu_top_i (
    .clk, .rst_n, .move_flush, .load_dispatch, .load_in, .store_commit, .store_in,
    .dmem_rsp, .dmem_req, .load_result, .load_result_valid, .load_rs_full, .store_q_full
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  task automatic check_val(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
    if (expected !== actual) begin
      val_errs++;
      $display("error %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  function automatic logic [5:0] pick_word();
    if ({$random(seed)} % 2 == 0) begin
      return {$random(seed)} % 8;  // Narrow window for same-word hits
    end
    return {$random(seed)} % 64;
  endfunction

  task automatic pick_access(input bit for_store, output lsu_types_pkg::mem_funct3_t f3,
                             output logic [1:0] off);
    case ({$random(seed)} % (for_store ? 3 : 5))
      0: f3 = lsu_types_pkg::mem_b;
      1: f3 = lsu_types_pkg::mem_h;
      2: f3 = lsu_types_pkg::mem_w;
      3: f3 = lsu_types_pkg::mem_bu;
      default: f3 = lsu_types_pkg::mem_hu;
    endcase
    if (f3 == lsu_types_pkg::mem_w) begin
      off = 2'd0;
    end else if (f3 == lsu_types_pkg::mem_h || f3 == lsu_types_pkg::mem_hu) begin
      off = 2'({$random(seed)} % 2) << 1;
    end else begin
      off = 2'({$random(seed)} % 4);
    end
  endtask

  function automatic logic [31:0] predict_load(input logic [31:0] word, input logic [1:0] off,
                                               input lsu_types_pkg::mem_funct3_t f3);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*off +: 8];
    h = word[16*off[1] +: 16];
    case (f3)
      lsu_types_pkg::mem_b:  return {{24{b[7]}}, b};
      lsu_types_pkg::mem_bu: return {24'h0, b};
      lsu_types_pkg::mem_h:  return {{16{h[15]}}, h};
      lsu_types_pkg::mem_hu: return {16'h0, h};
      default: return word;
    endcase
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int t = 0; t < 32; t++) begin
      n += pend[t];
    end
    return n;
  endfunction

  task automatic try_dispatch(output bit ok);
    lsu_types_pkg::mem_funct3_t f3;
    logic [1:0]                 off;
    logic [5:0]                 w;
    logic [4:0]                 tag;
    ok = 1'b0;
    for (int i = 0; i < 8 && !ok; i++) begin
      tag = 5'($random(seed));
      ok  = !pend[tag] && !flushed[tag];  // Flushed tags stay retired
    end
    if (ok) begin
      pick_access(1'b0, f3, off);
      w              = pick_word();
      pend[tag]      = 1'b1;
      pend_word[tag] = w;
      exp_data[tag]  = predict_load(shadow[w], off, f3);
      load_in <= '{tag: tag, addr: {24'h0, w, off}, funct3: f3};
    end
  endtask

  task automatic try_commit(output bit ok);
    lsu_types_pkg::mem_funct3_t f3;
    mem_bus_pkg::dmem_req_t     e;
    logic [1:0]                 off;
    logic [5:0]                 w;
    logic [31:0]                data;
    w  = pick_word();
    ok = 1'b1;
    for (int t = 0; t < 32; t++) begin
      if (pend[t] && pend_word[t] == w) ok = 1'b0;  // Older load to this word still open
    end
    if (ok) begin
      pick_access(1'b1, f3, off);
      data        = $random(seed);
      e           = '0;
      e.valid     = 1'b1;
      e.write     = 1'b1;
      e.word_addr = {24'h0, w};
      case (f3)
        lsu_types_pkg::mem_b: begin
          e.mask  = 4'b0001 << off;
          e.wdata = {24'h0, data[7:0]} << (8 * off);
        end
        lsu_types_pkg::mem_h: begin
          e.mask  = 4'b0011 << off;
          e.wdata = {16'h0, data[15:0]} << (8 * off);
        end
        default: begin
          e.mask  = 4'b1111;
          e.wdata = data;
        end
      endcase
      for (int k = 0; k < 4; k++) begin
        if (e.mask[k]) shadow[w][8*k +: 8] = e.wdata[8*k +: 8];
      end
      exp_writes.push_back(e);
      n_commits++;
      store_in <= '{addr: {24'h0, w, off}, data: data, funct3: f3};
    end
  endtask

  task automatic step();
    mem_bus_pkg::dmem_req_t req;
    mem_bus_pkg::dmem_req_t e;
    mem_bus_pkg::dmem_rsp_t rsp;
    bit                     do_flush;
    bit                     ok_ld;
    bit                     ok_st;
    int                     strobe_sq;  // Queued stores in the cycle of the grant
    @(posedge clk);
    req       = dmem_req;
    strobe_sq = sq_cnt_q;
    sq_cnt_q  = sq_cnt;
    do_flush  = 1'b0;
    ok_ld     = 1'b0;
    ok_st     = 1'b0;
    if (load_rs_full) full_seen = 1'b1;
    check_val("store_q_full", sq_cnt == `LSU_STORE_Q_DEPTH, store_q_full);
    if (load_result_valid && !pend[load_result.tag]) begin
      other_errs++;
      $display("load result for tag %0d, which has no outstanding load", load_result.tag);
    end else if (load_result_valid) begin
      check_val($sformatf("load_data_tag_%0d", load_result.tag), exp_data[load_result.tag],
                load_result.data);
      pend[load_result.tag] = 1'b0;
    end
    if (mem_state == 0 && req.valid) begin
      check_val("req_is_write", strobe_sq > 0, req.write);  // A queued store always wins
      check_val("req_is_read", strobe_sq == 0, req.read);
      if (req.write && exp_writes.size() == 0) begin
        other_errs++;
        $display("write request on the port with no committed store left");
      end else if (req.write) begin
        e = exp_writes.pop_front();
        check_val("write_word_addr", e.word_addr, req.word_addr);
        check_val("write_mask", e.mask, req.mask);
        check_val("write_data", e.wdata, req.wdata);
      end
      cur_req   = req;
      mem_cnt   = slow_mem ? 24 : 1 + {$random(seed)} % 5;
      mem_state = 1;
    end else if (mem_state == 1) begin
      mem_cnt--;
      if (mem_cnt == 0) begin
        for (int k = 0; k < 4; k++) begin
          if (cur_req.write && cur_req.mask[k]) begin
            memory[cur_req.word_addr[5:0]][8*k +: 8] = cur_req.wdata[8*k +: 8];
          end
        end
        n_writes += cur_req.write;
        rsp.resp  = 1'b1;
        rsp.rdata = memory[cur_req.word_addr[5:0]];
        dmem_rsp <= rsp;
        mem_state = 2;
      end
    end else if (mem_state == 2) begin
      dmem_rsp <= '0;
      mem_state = 0;
      if (cur_req.write) begin
        sq_cnt--;  // Queue pops on this edge
        do_flush = ({$random(seed)} % 100) < flush_pct;
      end
    end
    if (store_commit) sq_cnt++;
    for (int t = 0; t < 32; t++) begin
      if (do_flush && pend[t]) begin
        pend[t]    = 1'b0;
        flushed[t] = 1'b1;
        n_flushed++;
      end
    end
    if (!do_flush && !load_dispatch && !load_rs_full && ({$random(seed)} % 100) < load_pct) begin
      try_dispatch(ok_ld);
    end
    if (!store_commit && !store_q_full && ({$random(seed)} % 100) < store_pct) begin
      try_commit(ok_st);
    end
    move_flush    <= do_flush;
    load_dispatch <= ok_ld;
    store_commit  <= ok_st;
  endtask

  task automatic wait_drain(input string what);
    int guard;
    guard = 0;
    while ((outstanding() != 0 || exp_writes.size() != 0 || mem_state != 0) && guard < 3000) begin
      step();
      guard++;
    end
    if (guard >= 3000) begin
      other_errs++;
      $display("timeout while waiting for %s", what);
    end
  endtask

  initial begin
    int guard;
    int base;
    seed = 74852;
    {val_errs, other_errs, mem_state, mem_cnt, sq_cnt, sq_cnt_q} = '0;
    {n_commits, n_writes, n_flushed, load_pct, store_pct, flush_pct} = '0;
    {slow_mem, full_seen} = '0;
    for (int i = 0; i < 64; i++) begin
      memory[i] = (32'h9e37_79b9 * (i + 1)) ^ {26'h0, i[5:0]};
      shadow[i] = memory[i];
    end
    rst_n         = 1'b0;
    move_flush    = 1'b0;
    load_dispatch = 1'b0;
    load_in       = '0;
    store_commit  = 1'b0;
    store_in      = '0;
    dmem_rsp      = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    load_pct  = 40;  // Mixed traffic with occasional flushes
    store_pct = 40;
    flush_pct = 6;
    repeat (600) step();
    {load_pct, store_pct, flush_pct} = '0;
    wait_drain("the unit to drain after random traffic");

    slow_mem  = 1'b1;  // Hold stores so loads pile up behind them
    store_pct = 100;
    base      = n_commits;
    guard     = 0;
    while (n_commits < base + 3 && guard < 200) begin
      step();
      guard++;
    end
    if (guard >= 200) begin
      other_errs++;
      $display("timeout while committing stores for the back-pressure test");
    end
    store_pct = 0;
    load_pct  = 100;
    full_seen = 1'b0;
    guard     = 0;
    while (!full_seen && guard < 200) begin
      step();
      guard++;
    end
    if (!full_seen) begin
      other_errs++;
      $display("load_rs_full never rose with the station full of blocked loads");
    end
    load_pct = 0;
    slow_mem = 1'b0;
    wait_drain("blocked loads and stores to complete");

    check_val("stores_written", n_commits, n_writes);
    for (int i = 0; i < 64; i++) begin
      check_val($sformatf("mem_word_%0d", i), shadow[i], memory[i]);
    end
    if (n_flushed == 0) begin
      other_errs++;
      $display("no load was waiting in the station when a flush was applied");
    end
    $display("value errors: %0d, other errors: %0d", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
hdl/lsu_types_pkg.sv
hdl/mem_bus_pkg.sv
hdl/load_rs.sv
hdl/store_queue.sv
hdl/load_store_fsm.sv
hdl/dmem_port.sv
hdl/lsu_top.sv
sim/lsu_tb.sv
